// File: all.f
+incdir+design
design/genesis_bus_pkg.sv
design/mbus_if.sv
design/mbus_ctrl.sv
design/work_ram.sv
design/zbus_ctrl.sv
design/z80_ctrl_regs.sv
design/genesis_bus.sv
dv/genesis_bus_properties.sv
dv/tb_genesis_bus.sv

// File: design/genesis_bus.sv
// Console main-bus top level
module genesis_bus (
	input  logic                        MCLK,
	input  logic                        reset,
	// 68000 port
	input  logic                        m68k_as_n,
	input  genesis_bus_pkg::m68k_addr_t m68k_addr,
	input  genesis_bus_pkg::bus_data_t  m68k_wdata,
	input  logic                        m68k_rnw,
	input  logic                        m68k_uds_n,
	input  logic                        m68k_lds_n,
	output genesis_bus_pkg::bus_data_t  m68k_rdata,
	output logic                        m68k_dtack_n,
	// Cartridge ROM
	input  genesis_bus_pkg::m68k_addr_t rom_size,
	output genesis_bus_pkg::m68k_addr_t rom_addr,
	input  genesis_bus_pkg::bus_data_t  rom_rdata,
	output logic                        rom_req,
	input  logic                        rom_ack,
	// Z80 port
	input  logic                        z80_req,
	input  genesis_bus_pkg::zbus_addr_t z80_addr,
	input  genesis_bus_pkg::bus_byte_t  z80_wdata,
	input  logic                        z80_wr_n,
	output genesis_bus_pkg::bus_byte_t  z80_rdata,
	output logic                        z80_dtack_n,
	input  logic                        z80_busak_n,
	output logic                        z80_busrq_n,
	output logic                        z80_reset_n
);

	logic                       ram_sel;
	logic                       zbus_sel;
	logic                       ctrl_sel;
	logic                       zbus_dtack_n;
	logic                       zbus_free;
	genesis_bus_pkg::bus_data_t ram_rdata;
	genesis_bus_pkg::bus_byte_t zbus_rdata;
	genesis_bus_pkg::bus_data_t ctrl_rdata;
	genesis_bus_pkg::bus_data_t open_bus;

	mbus_if mbus0 ();

	// ROM sees the latched cycle address
	assign rom_addr = mbus0.addr;

	mbus_ctrl mbus_ctrl0 (.bus(mbus0), .*);

	work_ram work_ram0 (.bus(mbus0), .*);

	zbus_ctrl zbus_ctrl0 (.bus(mbus0), .*);

	z80_ctrl_regs z80_ctrl_regs0 (.bus(mbus0), .*);

endmodule

// File: design/genesis_bus_consts.svh
// Main-bus address map and sizes
`ifndef GENESIS_BUS_CONSTS_SVH
`define GENESIS_BUS_CONSTS_SVH

// Open-bus word after reset, a 68000 NOP
`define GB_OPEN_BUS_INIT 16'h4E71

// ROM region ends below A00000
`define GB_ROM_LIMIT_HI 4'hA

// Z80 bus window at A00000
`define GB_ZBUS_PAGE 8'hA0

// Z80 control page at A11xxx
`define GB_CTRL_PAGE 12'hA11

// Work RAM and Z80 RAM address widths
`define GB_WRAM_AW 15
`define GB_ZRAM_AW 13

// Read value for unmapped Z80-bus addresses
`define GB_UNMAPPED_Z 8'hFF

`endif

// File: design/genesis_bus_pkg.sv
// Shared bus types
package genesis_bus_pkg;

	// 68000 word address, indexed like the byte address
	typedef logic [23:1] m68k_addr_t;
	typedef logic [15:0] bus_data_t;
	typedef logic [7:0]  bus_byte_t;
	typedef logic [14:0] zbus_addr_t;

	typedef enum logic [2:0] {
		MBUS_IDLE,
		MBUS_SELECT,
		MBUS_RAM_READ,
		MBUS_ROM_READ,
		MBUS_ZBUS_PRE,
		MBUS_ZBUS_READ,
		MBUS_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {ZBUS_IDLE, ZBUS_READ, ZBUS_FINISH} zbus_state_t;

	// Arbiter masters
	typedef enum logic {SRC_MBUS, SRC_Z80} zbus_src_t;

endpackage

// File: design/mbus_ctrl.sv
// Main-bus controller
`include "genesis_bus_consts.svh"

module mbus_ctrl (
	input  logic                        MCLK,
	input  logic                        reset,
	input  logic                        m68k_as_n,
	input  genesis_bus_pkg::m68k_addr_t m68k_addr,
	input  genesis_bus_pkg::bus_data_t  m68k_wdata,
	input  logic                        m68k_rnw,
	input  logic                        m68k_uds_n,
	input  logic                        m68k_lds_n,
	input  genesis_bus_pkg::m68k_addr_t rom_size,
	input  genesis_bus_pkg::bus_data_t  rom_rdata,
	input  logic                        rom_ack,
	input  genesis_bus_pkg::bus_data_t  ram_rdata,
	input  genesis_bus_pkg::bus_byte_t  zbus_rdata,
	input  logic                        zbus_dtack_n,
	input  genesis_bus_pkg::bus_data_t  ctrl_rdata,
	output genesis_bus_pkg::bus_data_t  m68k_rdata,
	output logic                        m68k_dtack_n,
	output logic                        rom_req,
	output logic                        ram_sel,
	output logic                        zbus_sel,
	output logic                        ctrl_sel,
	output genesis_bus_pkg::bus_data_t  open_bus,
	mbus_if.ctrl                        bus
);

	genesis_bus_pkg::mbus_state_t state;
	genesis_bus_pkg::bus_data_t   data;

	logic in_rom;
	logic in_zbus;
	logic in_ctrl;
	logic in_wram;

	// ----------------------------------------------------------------------
	// Address decode on the latched cycle
	// ----------------------------------------------------------------------
	assign in_rom  = bus.addr[23:20] < `GB_ROM_LIMIT_HI;
	assign in_zbus = bus.addr[23:16] == `GB_ZBUS_PAGE;
	assign in_ctrl = bus.addr[23:12] == `GB_CTRL_PAGE;
	assign in_wram = &bus.addr[23:21];

	// ----------------------------------------------------------------------
	// Bus cycle FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= genesis_bus_pkg::MBUS_IDLE;
			m68k_dtack_n <= 1'b1;
			rom_req      <= rom_ack;
			ram_sel      <= 1'b0;
			zbus_sel     <= 1'b0;
			ctrl_sel     <= 1'b0;
			open_bus     <= `GB_OPEN_BUS_INIT;
		end else begin
			ctrl_sel <= 1'b0;
			if (m68k_as_n)
				m68k_dtack_n <= 1'b1;

			case (state)
				genesis_bus_pkg::MBUS_IDLE: begin
					// Wait for the previous DTACK to clear first
					if (!m68k_as_n && m68k_dtack_n) begin
						bus.addr  <= m68k_addr;
						bus.wdata <= m68k_wdata;
						bus.rnw   <= m68k_rnw;
						bus.uds_n <= m68k_uds_n;
						bus.lds_n <= m68k_lds_n;
						data      <= open_bus;
						state     <= genesis_bus_pkg::MBUS_SELECT;
					end
				end
				genesis_bus_pkg::MBUS_SELECT: begin
					// Unmapped space keeps the open-bus word
					state <= genesis_bus_pkg::MBUS_FINISH;
					if (in_rom) begin
						if (bus.addr < rom_size) begin
							rom_req <= ~rom_ack;
							state   <= genesis_bus_pkg::MBUS_ROM_READ;
						end else begin
							data <= '0;
						end
					end else if (in_zbus) begin
						state <= genesis_bus_pkg::MBUS_ZBUS_PRE;
					end else if (in_ctrl) begin
						ctrl_sel <= 1'b1;
						data     <= ctrl_rdata;
					end else if (in_wram) begin
						ram_sel <= 1'b1;
						state   <= genesis_bus_pkg::MBUS_RAM_READ;
					end
				end
				genesis_bus_pkg::MBUS_RAM_READ: begin
					ram_sel <= 1'b0;
					data    <= ram_rdata;
					if (bus.rnw)
						open_bus <= ram_rdata;
					state <= genesis_bus_pkg::MBUS_FINISH;
				end
				genesis_bus_pkg::MBUS_ROM_READ: begin
					if (rom_req == rom_ack) begin
						data     <= rom_rdata;
						open_bus <= rom_rdata;
						state    <= genesis_bus_pkg::MBUS_FINISH;
					end
				end
				genesis_bus_pkg::MBUS_ZBUS_PRE: begin
					zbus_sel <= 1'b1;
					state    <= genesis_bus_pkg::MBUS_ZBUS_READ;
				end
				genesis_bus_pkg::MBUS_ZBUS_READ: begin
					// Z80 side is 8 bits wide, same byte on both lanes
					if (!zbus_dtack_n) begin
						zbus_sel <= 1'b0;
						data     <= {zbus_rdata, zbus_rdata};
						state    <= genesis_bus_pkg::MBUS_FINISH;
					end
				end
				genesis_bus_pkg::MBUS_FINISH: begin
					m68k_rdata   <= data;
					m68k_dtack_n <= 1'b0;
					state        <= genesis_bus_pkg::MBUS_IDLE;
				end
				default: state <= genesis_bus_pkg::MBUS_IDLE;
			endcase
		end
	end

endmodule

// File: design/mbus_if.sv
// Latched main-bus cycle
interface mbus_if;

	genesis_bus_pkg::m68k_addr_t addr;
	genesis_bus_pkg::bus_data_t  wdata;
	logic                        rnw;
	logic                        uds_n;
	logic                        lds_n;

	// Controller owns the cycle, slaves only look at it
	modport ctrl (
		output addr, wdata, rnw, uds_n, lds_n
	);
	modport slave (
		input addr, wdata, rnw, uds_n, lds_n
	);

endinterface

// File: design/work_ram.sv
// 68000 work RAM
`include "genesis_bus_consts.svh"

module work_ram #(
	parameter int addr_w = `GB_WRAM_AW
) (
	input  logic                       MCLK,
	mbus_if.slave                      bus,
	input  logic                       ram_sel,
	output genesis_bus_pkg::bus_data_t ram_rdata
);

	genesis_bus_pkg::bus_byte_t mem_u [2**addr_w];
	genesis_bus_pkg::bus_byte_t mem_l [2**addr_w];
	logic [addr_w-1:0]          idx;
	logic                       wr;

	// Upper address bits ignored, so the region mirrors
	assign idx = bus.addr[addr_w:1];
	assign wr  = ram_sel & ~bus.rnw;

	// One lane per data strobe
	always_ff @(posedge MCLK) begin
		if (wr && !bus.uds_n)
			mem_u[idx] <= bus.wdata[15:8];
		if (wr && !bus.lds_n)
			mem_l[idx] <= bus.wdata[7:0];
		ram_rdata <= {mem_u[idx], mem_l[idx]};
	end

endmodule

// File: design/z80_ctrl_regs.sv
// Z80 bus-request and reset registers
module z80_ctrl_regs (
	input  logic                       MCLK,
	input  logic                       reset,
	mbus_if.slave                      bus,
	input  logic                       ctrl_sel,
	input  genesis_bus_pkg::bus_data_t open_bus,
	input  logic                       z80_busak_n,
	output genesis_bus_pkg::bus_data_t ctrl_rdata,
	output logic                       z80_busrq_n,
	output logic                       z80_reset_n,
	output logic                       zbus_free
);

	logic [3:0] page;
	logic       flag;

	// Page 1 is the bus request, page 2 the reset line
	assign page = bus.addr[11:8];
	assign flag = (page == 4'd1) ? z80_busak_n :
	              (page == 4'd2) ? z80_reset_n : open_bus[8];

	// Only bit 8 is driven, the rest floats
	assign ctrl_rdata = {open_bus[15:9], flag, open_bus[7:0]};
	assign zbus_free  = ~z80_busrq_n & z80_reset_n;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			z80_busrq_n <= 1'b1;
			z80_reset_n <= 1'b0;
		end else if (ctrl_sel && !bus.rnw && !bus.uds_n) begin
			if (page == 4'd1)
				z80_busrq_n <= ~bus.wdata[8];
			if (page == 4'd2)
				z80_reset_n <= bus.wdata[8];
		end
	end

endmodule

// File: design/zbus_ctrl.sv
// Z80-bus arbiter with Z80 RAM
`include "genesis_bus_consts.svh"

module zbus_ctrl (
	input  logic                        MCLK,
	input  logic                        reset,
	mbus_if.slave                       bus,
	input  logic                        zbus_sel,
	input  logic                        zbus_free,
	input  logic                        z80_req,
	input  genesis_bus_pkg::zbus_addr_t z80_addr,
	input  genesis_bus_pkg::bus_byte_t  z80_wdata,
	input  logic                        z80_wr_n,
	output genesis_bus_pkg::bus_byte_t  zbus_rdata,
	output logic                        zbus_dtack_n,
	output genesis_bus_pkg::bus_byte_t  z80_rdata,
	output logic                        z80_dtack_n
);

	genesis_bus_pkg::zbus_state_t state;
	genesis_bus_pkg::zbus_src_t   src;
	genesis_bus_pkg::zbus_addr_t  za;
	genesis_bus_pkg::bus_byte_t   zdo;
	logic                         zwe;

	genesis_bus_pkg::bus_byte_t   zram [2**`GB_ZRAM_AW];
	genesis_bus_pkg::bus_byte_t   zram_q;
	genesis_bus_pkg::bus_byte_t   zbus_di;
	logic                         zram_hit;

	// RAM at 0000-3FFF, mirrored every 8 KB
	assign zram_hit = ~za[14];
	assign zbus_di  = zram_hit ? zram_q : `GB_UNMAPPED_Z;

	always_ff @(posedge MCLK) begin
		if (zwe && zram_hit)
			zram[za[`GB_ZRAM_AW-1:0]] <= zdo;
		zram_q <= zram[za[`GB_ZRAM_AW-1:0]];
	end

	// ----------------------------------------------------------------------
	// Arbiter, main bus first on a tie
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= genesis_bus_pkg::ZBUS_IDLE;
			src          <= genesis_bus_pkg::SRC_MBUS;
			zwe          <= 1'b0;
			zbus_dtack_n <= 1'b1;
			z80_dtack_n  <= 1'b1;
		end else begin
			zwe <= 1'b0;
			if (!zbus_sel)
				zbus_dtack_n <= 1'b1;
			if (!z80_req)
				z80_dtack_n <= 1'b1;

			case (state)
				genesis_bus_pkg::ZBUS_IDLE: begin
					if (zbus_sel && zbus_dtack_n) begin
						// Even byte rides the upper lane
						za    <= {bus.addr[14:1], bus.uds_n};
						zdo   <= bus.uds_n ? bus.wdata[7:0] : bus.wdata[15:8];
						zwe   <= ~bus.rnw & zbus_free;
						src   <= genesis_bus_pkg::SRC_MBUS;
						state <= genesis_bus_pkg::ZBUS_READ;
					end else if (z80_req && z80_dtack_n) begin
						za    <= z80_addr;
						zdo   <= z80_wdata;
						zwe   <= ~z80_wr_n;
						src   <= genesis_bus_pkg::SRC_Z80;
						state <= genesis_bus_pkg::ZBUS_READ;
					end
				end
				genesis_bus_pkg::ZBUS_READ: state <= genesis_bus_pkg::ZBUS_FINISH;
				genesis_bus_pkg::ZBUS_FINISH: begin
					if (src == genesis_bus_pkg::SRC_MBUS) begin
						// Z80 still owns its bus
						zbus_rdata   <= zbus_free ? zbus_di : 8'hFF;
						zbus_dtack_n <= 1'b0;
					end else begin
						z80_rdata   <= zbus_di;
						z80_dtack_n <= 1'b0;
					end
					state <= genesis_bus_pkg::ZBUS_IDLE;
				end
				default: state <= genesis_bus_pkg::ZBUS_IDLE;
			endcase
		end
	end

endmodule

// File: dv/genesis_bus_properties.sv
// Bus handshake assertions
module genesis_bus_properties (
	input logic MCLK,
	input logic reset,
	input logic m68k_as_n,
	input logic m68k_dtack_n,
	input logic rom_req,
	input logic rom_ack,
	input logic z80_req,
	input logic z80_dtack_n
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned violations = 0;

	// DTACK only answers a cycle that is still strobed
	assert property (@(posedge MCLK) disable iff (reset)
		$fell(m68k_dtack_n) |-> !$past(m68k_as_n))
	else begin
		violations++;
		$error("m68k_dtack_n fell while m68k_as_n was high");
	end

	// New ROM request only after the last one was acknowledged
	assert property (@(posedge MCLK) disable iff (reset)
		$changed(rom_req) |-> $past(rom_req == rom_ack))
	else begin
		violations++;
		$error("rom_req toggled with an access still open");
	end

	assert property (@(posedge MCLK) disable iff (reset)
		$fell(z80_dtack_n) |-> $past(z80_req))
	else begin
		violations++;
		$error("z80_dtack_n fell without a Z80 request");
	end

endmodule

bind genesis_bus genesis_bus_properties props0 (.*);

// File: dv/tb_genesis_bus.sv
// Main-bus controller testbench
`include "genesis_bus_consts.svh"

module tb_genesis_bus;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int   M68K = 0;
	localparam int   Z80  = 1;
	localparam int   DUAL = 2;
	localparam logic RD   = 1'b0;
	localparam logic WR   = 1'b1;

	logic MCLK, reset, m68k_as_n, m68k_rnw, m68k_uds_n, m68k_lds_n, m68k_dtack_n;
	logic rom_req, rom_ack, z80_req, z80_wr_n, z80_dtack_n;
	logic z80_busak_n, z80_busrq_n, z80_reset_n;
	genesis_bus_pkg::m68k_addr_t m68k_addr, rom_size, rom_addr;
	genesis_bus_pkg::bus_data_t  m68k_wdata, m68k_rdata, rom_rdata;
	genesis_bus_pkg::bus_byte_t  z80_wdata, z80_rdata;
	genesis_bus_pkg::zbus_addr_t z80_addr;

	// Stimulus table, strobes are {uds_n, lds_n}
	// DUAL entries keep the Z80 address in t_data
	string       t_name[$];
	int          t_port[$];
	logic [23:0] t_addr[$];
	logic        t_wr[$];
	logic [1:0]  t_strb[$];
	logic [15:0] t_data[$];
	logic [15:0] t_exp[$];

	logic        table_ready = 1'b0;
	logic [31:0] rnd = 32'h06ea_4cb6;
	int          errors = 0;

	genesis_bus dut0 (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic add_entry(input string name, input int port, input logic [23:0] addr,
			input logic wr, input logic [1:0] strb, input logic [15:0] data,
			input logic [15:0] exp);
		t_name.push_back(name);
		t_port.push_back(port);
		t_addr.push_back(addr);
		t_wr.push_back(wr);
		t_strb.push_back(strb);
		t_data.push_back(data);
		t_exp.push_back(exp);
	endtask

	task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] got);
		assert (got === exp)
		else begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	// ----------------------------------------------------------------------
	// Bus masters
	// ----------------------------------------------------------------------
	task automatic m68k_cycle(input logic [23:0] addr, input logic wr, input logic [1:0] strb,
			input logic [15:0] wdata, output genesis_bus_pkg::bus_data_t rdata);
		m68k_addr                = addr[23:1];
		m68k_wdata               = wdata;
		m68k_rnw                 = ~wr;
		{m68k_uds_n, m68k_lds_n} = strb;
		m68k_as_n                = 1'b0;
		do
			@(negedge MCLK);
		while (m68k_dtack_n);
		rdata     = m68k_rdata;
		m68k_as_n = 1'b1;
		@(negedge MCLK);
	endtask

	task automatic z80_cycle(input genesis_bus_pkg::zbus_addr_t addr, input logic wr,
			input genesis_bus_pkg::bus_byte_t wdata, output genesis_bus_pkg::bus_byte_t rdata);
		z80_addr  = addr;
		z80_wdata = wdata;
		z80_wr_n  = ~wr;
		z80_req   = 1'b1;
		do
			@(negedge MCLK);
		while (z80_dtack_n);
		rdata   = z80_rdata;
		z80_req = 1'b0;
		@(negedge MCLK);
	endtask

	task automatic run_entry(input int i);
		genesis_bus_pkg::bus_data_t got;
		genesis_bus_pkg::bus_byte_t zgot;
		got  = '0;
		zgot = '0;
		case (t_port[i])
			M68K: m68k_cycle(t_addr[i], t_wr[i], t_strb[i], t_data[i], got);
			Z80: begin
				z80_cycle(t_addr[i][14:0], t_wr[i], t_data[i][7:0], zgot);
				got = {8'h00, zgot};
			end
			default: begin
				// Z80 request reaches the arbiter on the same clock as zbus_sel
				fork
					m68k_cycle(t_addr[i], RD, t_strb[i], 16'h0000, got);
					begin
						repeat (3) @(negedge MCLK);
						z80_cycle(t_data[i][14:0], RD, 8'h00, zgot);
					end
				join
				got = {got[15:8], zgot};
			end
		endcase
		if (!t_wr[i])
			compare(t_name[i], t_exp[i], got);
	endtask

	task automatic build_table();
		add_entry("open_bus_init", M68K, 24'hC00000, RD, 2'b00, 16'h0000, `GB_OPEN_BUS_INIT);
		add_entry("ctrl_busak_idle", M68K, 24'hA11100, RD, 2'b00, 16'h0000, 16'h4F71);
		add_entry("wram_word_wr", M68K, 24'hFF0000, WR, 2'b00, 16'hA55A, 16'h0000);
		add_entry("wram_word_rd", M68K, 24'hFF0000, RD, 2'b00, 16'h0000, 16'hA55A);
		add_entry("open_bus_ram", M68K, 24'hC00000, RD, 2'b00, 16'h0000, 16'hA55A);
		add_entry("wram_fill", M68K, 24'hFF0002, WR, 2'b00, 16'h1234, 16'h0000);
		add_entry("wram_upper_wr", M68K, 24'hFF0002, WR, 2'b01, 16'hBEEF, 16'h0000);
		add_entry("wram_mirror_rd", M68K, 24'hE00002, RD, 2'b00, 16'h0000, 16'hBE34);
		add_entry("wram_lower_wr", M68K, 24'hFF0003, WR, 2'b10, 16'h00C7, 16'h0000);
		add_entry("wram_lower_rd", M68K, 24'hFF0002, RD, 2'b00, 16'h0000, 16'hBEC7);
		add_entry("rom_rd", M68K, 24'h001234, RD, 2'b00, 16'h0000, 16'h1A09);
		add_entry("open_bus_rom", M68K, 24'hC00000, RD, 2'b00, 16'h0000, 16'h1A09);
		add_entry("rom_rd_high", M68K, 24'h02468A, RD, 2'b00, 16'h0000, 16'h4523);
		add_entry("rom_past_size", M68K, 24'h100000, RD, 2'b00, 16'h0000, 16'h0000);
		add_entry("z80_seed", Z80, 24'h000010, WR, 2'b00, 16'h0011, 16'h0000);
		add_entry("zbus_wr_blocked", M68K, 24'hA00010, WR, 2'b01, 16'h2200, 16'h0000);
		add_entry("zbus_rd_blocked", M68K, 24'hA00010, RD, 2'b01, 16'h0000,
			{2{`GB_UNMAPPED_Z}});
		add_entry("ctrl_busreq", M68K, 24'hA11100, WR, 2'b00, 16'h0100, 16'h0000);
		add_entry("ctrl_reset_off", M68K, 24'hA11200, WR, 2'b00, 16'h0100, 16'h0000);
		add_entry("ctrl_busak_held", M68K, 24'hA11100, RD, 2'b00, 16'h0000, 16'h4423);
		add_entry("zbus_rd_kept", M68K, 24'hA00010, RD, 2'b01, 16'h0000, 16'h1111);
		add_entry("z80_wr_odd", Z80, 24'h000021, WR, 2'b00, 16'h005A, 16'h0000);
		add_entry("m68k_rd_odd", M68K, 24'hA00021, RD, 2'b10, 16'h0000, 16'h5A5A);
		add_entry("m68k_wr_even", M68K, 24'hA00030, WR, 2'b01, 16'hC300, 16'h0000);
		add_entry("z80_rd_even", Z80, 24'h000030, RD, 2'b00, 16'h0000, 16'h00C3);
		add_entry("z80_rd_mirror", Z80, 24'h002030, RD, 2'b00, 16'h0000, 16'h00C3);
		add_entry("z80_rd_unmapped", Z80, 24'h004000, RD, 2'b00, 16'h0000,
			{8'h00, `GB_UNMAPPED_Z});
		add_entry("m68k_rd_unmapped", M68K, 24'hA06000, RD, 2'b00, 16'h0000,
			{2{`GB_UNMAPPED_Z}});
		add_entry("dual_even", DUAL, 24'hA00030, RD, 2'b00, 16'h0021, 16'hC35A);
		add_entry("dual_odd", DUAL, 24'hA00021, RD, 2'b10, 16'h0010, 16'h5A11);
	endtask

	// ----------------------------------------------------------------------
	// Clock, ROM and Z80 models
	// ----------------------------------------------------------------------
	initial begin
		MCLK = 1'b0;
		forever #20 MCLK = ~MCLK;
	end

	// ROM answers with the swapped low word address after a random delay
	initial begin
		rom_ack   = 1'b0;
		rom_rdata = '0;
		forever begin
			@(negedge MCLK);
			if (!reset && rom_req !== rom_ack) begin
				rnd = xorshift(rnd);
				repeat (rnd % 6) @(negedge MCLK);
				rom_rdata = {rom_addr[8:1], rom_addr[16:9]};
				rom_ack   = rom_req;
			end
		end
	end

	// Z80 grants its bus half a clock after the request
	initial begin
		z80_busak_n = 1'b1;
		forever begin
			@(negedge MCLK);
			z80_busak_n = z80_busrq_n;
		end
	end

	initial begin
		wait (table_ready);
		repeat (t_name.size() * 200) @(posedge MCLK);
		$display("Watchdog expired, a bus cycle never completed");
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		m68k_as_n  = 1'b1;
		m68k_addr  = '0;
		m68k_wdata = '0;
		m68k_rnw   = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		// 512 KB cartridge
		rom_size   = 23'h040000;
		z80_req    = 1'b0;
		z80_addr   = '0;
		z80_wdata  = '0;
		z80_wr_n   = 1'b1;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge MCLK);
		@(negedge MCLK);
		reset = 1'b0;
		assert (m68k_dtack_n && z80_dtack_n && z80_busrq_n && !z80_reset_n && rom_req == rom_ack)
		else begin
			errors++;
			$display("Outputs are not at their reset values after reset");
		end
		foreach (t_name[i])
			run_entry(i);
		$display("Done: %0d errors, %0d handshake violations", errors, dut0.props0.violations);
		if (errors == 0 && dut0.props0.violations == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
	--top-module tb_genesis_bus -o tb_genesis_bus \
	&& ./obj_dir/tb_genesis_bus | tee sim.log \
	&& grep -q "^SIMULATION PASSED$" sim.log \
	|| { echo "Run failed, see sim.log"; exit 1; }
